// File: include/board_config.svh
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// ------------------------------------------------------------
// Board clock and I/O counts

`define CLK_MHZ      50   // Onboard oscillator
`define W_KEY        2    // Onboard keys
`define W_SW         4    // Onboard switches, top one is reset
`define W_LED        8    // Onboard LEDs

// ------------------------------------------------------------
// TM1638 panel

`define W_TM_DIGIT   8    // Seven-segment digits
`define W_TM_KEY     8    // Panel keys
`define W_TM_LED     8    // Panel LEDs

// ------------------------------------------------------------
// Dividers, small values for simulation

`define SIO_CLK_DIV  4    // Clocks per half period of panel serial clock
`define I2S_SCK_DIV  2    // Clocks per half period of I2S bit clock
`define SCAN_CYCLES  4    // Clocks per digit in the display scan

`endif

// File: hw/board_pkg.sv
`default_nettype none

`include "board_config.svh"

package board_pkg;

    // ------------------------------------------------------------
    // Vectors with a meaning

    typedef logic        [7:0]              seg_t;     // Segment pattern, lit is 1
    typedef logic        [`W_TM_DIGIT-1:0]  digit_t;   // One-hot digit select
    typedef logic        [`W_LED-1:0]       led_t;     // LED vector
    typedef logic        [`W_TM_KEY-1:0]    key_t;     // Pressed is 1
    typedef logic signed [23:0]             sample_t;  // Microphone sample

    // ------------------------------------------------------------
    // Panel pins driven by the FPGA

    typedef struct packed {
        logic clk;      // Serial clock, idles high
        logic stb;      // Strobe, active low
        logic dio;      // Data out
        logic dio_oe;   // Data pin driven when 1
    } sio_t;

    // TM1638 refresh sequence
    typedef enum logic [2:0] {
        st_idle,        // Strobe high gap
        st_cmd_mode,    // Data command 0x40
        st_addr,        // Address 0xC0
        st_data,        // 16 display bytes
        st_cmd_disp,    // Display control 0x8F
        st_cmd_read,    // Read command 0x42
        st_read         // Four key bytes
    } tm_state_t;

endpackage

`default_nettype wire

// File: hw/inmp441_mic_i2s_receiver.sv
`default_nettype none

`include "board_config.svh"

module inmp441_mic_i2s_receiver
    import board_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    sd,       // Serial data from microphone
    output logic    sck,      // I2S bit clock
    output logic    ws,       // Word select, low for left
    output sample_t value     // Last left-channel sample
);

    localparam int div_last = `I2S_SCK_DIV - 1;

    logic [7:0] div_cnt;      // Half-period divider
    logic [5:0] bit_cnt;      // Slot in 64-bit frame
    logic       half;         // Half period done
    logic       sck_rise;
    logic       sck_fall;
    logic       in_data;      // Slot carries a left data bit
    logic       ws_d;         // For ws rise detect
    sample_t    shift;        // Left bits, MSB first

    // ------------------------------------------------------------
    // Bit clock and word select

    assign half     = (div_cnt == 8'(div_last));
    assign sck_rise = half & ~sck;
    assign sck_fall = half &  sck;
    assign ws       = bit_cnt[5];                    // Upper half of frame is right

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
        end
        else
        begin
            if (half)
            begin
                div_cnt <= '0;
                sck     <= ~sck;
            end
            else
                div_cnt <= div_cnt + 8'd1;

            if (sck_fall)
                bit_cnt <= bit_cnt + 6'd1;           // Slot advances on falling edge
        end
    end

    // ------------------------------------------------------------
    // Sample capture

    assign in_data = (bit_cnt != 6'd0) && (bit_cnt <= 6'd24);   // One slot delay after ws

    always_ff @(posedge clk)
    begin
        if (sck_rise && in_data)
            shift <= {shift[22:0], sd};              // MSB arrives first
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ws_d  <= 1'b0;
            value <= '0;
        end
        else
        begin
            ws_d <= ws;
            if (ws && !ws_d)
                value <= shift;                      // Left half just ended
        end
    end

endmodule

`default_nettype wire

// File: hw/tm1638_board_controller.sv
`default_nettype none

`include "board_config.svh"

module tm1638_board_controller
    import board_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  seg_t   hgfedcba,     // Segments of the selected digit, a in bit 0
    input  digit_t digit,        // One-hot digit from the scan
    input  led_t   ledr,         // Panel LEDs
    input  logic   sio_dio_in,   // Data pin as seen by the FPGA
    output key_t   keys,         // Panel keys, pressed is 1
    output sio_t   sio           // Panel pins
);

    localparam int div_last = `SIO_CLK_DIV - 1;
    localparam int n_data   = 2 * `W_TM_DIGIT;      // Segment and LED byte per digit

    // ------------------------------------------------------------
    // Segment image from the multiplexed scan

    seg_t seg_img [`W_TM_DIGIT];

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < `W_TM_DIGIT; i++)
        begin
            if (digit[i])
                seg_img[i] <= hgfedcba;             // Latch while selected
        end
    end

    // ------------------------------------------------------------
    // Serial timing

    tm_state_t  state;
    tm_state_t  ret_state;       // Command after the strobe gap
    logic [7:0] div_cnt;         // Half-period divider
    logic [3:0] bit_cnt;         // Bits clocked, 8 ends a byte
    logic [3:0] byte_cnt;        // Byte within a strobe
    logic [7:0] tx_next;         // Byte for current state
    logic [7:0] tx_q;            // Byte being shifted out
    logic [7:0] rx_q;            // Byte being read in
    key_t       key_acc;         // Keys from earlier read bytes
    logic       tick;            // Half period done
    logic       busy;            // Strobe low, bytes in flight
    logic       bit_fall;        // Serial clock goes low
    logic       bit_rise;        // Serial clock goes high
    logic       byte_end;

    assign tick     = (div_cnt == 8'(div_last));
    assign busy     = (state != st_idle);
    assign bit_fall = tick & busy & sio.clk & (bit_cnt != 4'd8);
    assign bit_rise = tick & busy & ~sio.clk;
    assign byte_end = tick & busy & sio.clk & (bit_cnt == 4'd8);

    always_comb
    begin
        case (state)
            st_cmd_mode: tx_next = 8'h40;                          // Write, auto increment
            st_addr:     tx_next = 8'hC0;                          // Start at address 0
            st_data:     tx_next = byte_cnt[0] ? {7'd0, ledr[byte_cnt[3:1]]}
                                               : seg_img[byte_cnt[3:1]];
            st_cmd_disp: tx_next = 8'h8F;                          // Display on, full bright
            st_cmd_read: tx_next = 8'h42;                          // Key scan read
            default:     tx_next = 8'h00;
        endcase
    end

    // ------------------------------------------------------------
    // Data shift registers

    always_ff @(posedge clk)
    begin
        if (bit_fall && bit_cnt == 4'd0)
            tx_q <= tx_next;                        // Hold byte stable while shifting

        if (bit_rise)
            rx_q <= {sio_dio_in, rx_q[7:1]};        // LSB first

        if (byte_end && state == st_read)
        begin
            key_acc[{1'b0, byte_cnt[1:0]}] <= rx_q[0];
            key_acc[{1'b1, byte_cnt[1:0]}] <= rx_q[4];
        end
    end

    // ------------------------------------------------------------
    // Command sequence FSM

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= st_idle;
            ret_state <= st_cmd_mode;
            div_cnt   <= '0;
            bit_cnt   <= '0;
            byte_cnt  <= '0;
            keys      <= '0;
            sio       <= '{clk: 1'b1, stb: 1'b1, dio: 1'b0, dio_oe: 1'b0};
        end
        else
        begin
            div_cnt <= tick ? 8'd0 : div_cnt + 8'd1;

            if (tick)
            begin
                if (!busy)                          // Gap over, open strobe
                begin
                    sio.stb    <= 1'b0;
                    sio.dio_oe <= 1'b1;
                    state      <= ret_state;
                end
                else if (!sio.clk)                  // Panel samples here
                begin
                    sio.clk <= 1'b1;
                    bit_cnt <= bit_cnt + 4'd1;
                end
                else if (bit_cnt != 4'd8)           // Next bit while clock low
                begin
                    sio.clk <= 1'b0;
                    if (state != st_read)
                        sio.dio <= (bit_cnt == 4'd0) ? tx_next[0] : tx_q[bit_cnt[2:0]];
                end
                else
                begin
                    bit_cnt <= '0;
                    case (state)
                        st_cmd_mode:
                        begin
                            sio.stb    <= 1'b1;
                            sio.dio_oe <= 1'b0;
                            ret_state  <= st_addr;
                            state      <= st_idle;
                        end
                        st_addr:
                        begin
                            byte_cnt <= '0;
                            state    <= st_data;     // Same strobe
                        end
                        st_data:
                        begin
                            if (byte_cnt == 4'(n_data - 1))
                            begin
                                sio.stb    <= 1'b1;
                                sio.dio_oe <= 1'b0;
                                ret_state  <= st_cmd_disp;
                                state      <= st_idle;
                            end
                            else
                                byte_cnt <= byte_cnt + 4'd1;
                        end
                        st_cmd_disp:
                        begin
                            sio.stb    <= 1'b1;
                            sio.dio_oe <= 1'b0;
                            ret_state  <= st_cmd_read;
                            state      <= st_idle;
                        end
                        st_cmd_read:
                        begin
                            byte_cnt   <= '0;
                            sio.dio_oe <= 1'b0;      // Panel takes the pin
                            state      <= st_read;
                        end
                        st_read:
                        begin
                            if (byte_cnt == 4'd3)    // End of refresh
                            begin
                                sio.stb   <= 1'b1;
                                keys      <= {rx_q[4], key_acc[6:4], rx_q[0], key_acc[2:0]};
                                ret_state <= st_cmd_mode;
                                state     <= st_idle;
                            end
                            else
                                byte_cnt <= byte_cnt + 4'd1;
                        end
                        default:
                            state <= st_idle;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/top.sv
`default_nettype none

`include "board_config.svh"

module top
    import board_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  key_t       key,        // Pressed is 1
    input  logic [2:0] sw,         // Not used by this design
    input  sample_t    mic,        // Left microphone sample
    output led_t       led,
    output seg_t       abcdefgh,   // a in bit 7
    output digit_t     digit       // One-hot digit select
);

    localparam int scan_last = `SCAN_CYCLES - 1;

    sample_t    held;              // Sample on display
    logic [3:0] scan_cnt;          // Clocks on current digit
    logic [3:0] nibble;            // Hex value of selected digit
    logic       blank;             // Digits 6 and 7 stay dark

    // ------------------------------------------------------------
    // Sample hold

    always_ff @(posedge clk)
    begin
        if (rst)
            held <= '0;
        else if (!key[0])
            held <= mic;           // Frozen while key 0 held
    end

    assign led = held[23:16];      // Upper byte

    // ------------------------------------------------------------
    // Digit scan

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            scan_cnt <= '0;
            digit    <= digit_t'(1);
        end
        else if (scan_cnt == 4'(scan_last))
        begin
            scan_cnt <= '0;
            digit    <= {digit[6:0], digit[7]};    // Rotate to next digit
        end
        else
            scan_cnt <= scan_cnt + 4'd1;
    end

    // ------------------------------------------------------------
    // Hex to segments

    function automatic seg_t hex_seg(input logic [3:0] h);
        case (h)
            4'h0: hex_seg = 8'hFC;
            4'h1: hex_seg = 8'h60;
            4'h2: hex_seg = 8'hDA;
            4'h3: hex_seg = 8'hF2;
            4'h4: hex_seg = 8'h66;
            4'h5: hex_seg = 8'hB6;
            4'h6: hex_seg = 8'hBE;
            4'h7: hex_seg = 8'hE0;
            4'h8: hex_seg = 8'hFE;
            4'h9: hex_seg = 8'hF6;
            4'hA: hex_seg = 8'hEE;
            4'hB: hex_seg = 8'h3E;    // Lower case b
            4'hC: hex_seg = 8'h9C;
            4'hD: hex_seg = 8'h7A;    // Lower case d
            4'hE: hex_seg = 8'h9E;
            default: hex_seg = 8'h8E;
        endcase
    endfunction

    always_comb
    begin
        nibble = '0;
        for (int i = 0; i < 6; i++)
        begin
            if (digit[i])
                nibble |= held[i * 4 +: 4];        // One-hot mux
        end
    end

    assign blank    = digit[6] | digit[7];
    assign abcdefgh = blank ? 8'h00 : hex_seg(nibble);

endmodule

`default_nettype wire

// File: hw/board_specific_top.sv
`default_nettype none

`include "board_config.svh"

module board_specific_top
    import board_pkg::*;
(
    input  logic              fpga_clk1_50,

    input  logic [`W_KEY-1:0] key,           // Onboard keys, active low
    input  logic [`W_SW-1:0]  sw,            // Top switch is reset
    input  logic              btn_reset_n,   // MiSTer I/O board reset button
    input  logic              mic_sd,
    input  logic              sio_dio_in,    // TM1638 data pin, input side

    output led_t              led,           // Onboard LEDs
    output logic              sio_clk,
    output logic              sio_stb,
    output logic              sio_dio,
    output logic              sio_dio_oe,
    output logic              mic_sck,
    output logic              mic_ws
);

    logic    clk;
    logic    rst;
    key_t    top_key;      // Merged onboard and panel keys
    key_t    tm_key;       // Keys read from the panel
    led_t    top_led;
    digit_t  top_digit;
    seg_t    abcdefgh;     // From user design, a in bit 7
    seg_t    hgfedcba;     // To panel, a in bit 0
    sio_t    sio;
    sample_t mic;

    assign clk = fpga_clk1_50;
    assign rst = sw[`W_SW-1] | ~btn_reset_n;

    // ------------------------------------------------------------
    // Key merge and LED fan-out

    always_comb
    begin
        top_key = '0;
        top_key[`W_KEY-1:0]    |= ~key;                        // Onboard active low
        top_key[`W_TM_KEY-2:0] |= tm_key[`W_TM_KEY-2:0];       // Panel key 7 not used
    end

    assign led = top_led;

    // Panel bit order is reversed
    for (genvar i = 0; i < 8; i++)
    begin : g_rev
        assign hgfedcba[i] = abcdefgh[7 - i];
    end

    assign sio_clk    = sio.clk;
    assign sio_stb    = sio.stb;
    assign sio_dio    = sio.dio;
    assign sio_dio_oe = sio.dio_oe;

    // ------------------------------------------------------------
    // Blocks

    top i_top
    (
        .clk      ( clk                ),
        .rst      ( rst                ),
        .key      ( top_key            ),
        .sw       ( sw[`W_SW-2:0]      ),   // Remaining switches
        .mic      ( mic                ),
        .led      ( top_led            ),
        .abcdefgh ( abcdefgh           ),
        .digit    ( top_digit          )
    );

    tm1638_board_controller i_ledkey
    (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .hgfedcba   ( hgfedcba   ),
        .digit      ( top_digit  ),
        .ledr       ( top_led    ),   // Same LEDs as onboard
        .sio_dio_in ( sio_dio_in ),
        .keys       ( tm_key     ),
        .sio        ( sio        )
    );

    inmp441_mic_i2s_receiver i_microphone
    (
        .clk   ( clk     ),
        .rst   ( rst     ),
        .sd    ( mic_sd  ),
        .sck   ( mic_sck ),
        .ws    ( mic_ws  ),
        .value ( mic     )
    );

endmodule

`default_nettype wire

// File: verif/board_assert.sv
`default_nettype none

module board_assert
    import board_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input sio_t      sio,
    input tm_state_t state
);
    timeunit 1ns;
    timeprecision 1ps;

    // Data only moves while the serial clock is low
    a_dio_stable: assert property (@(posedge clk) disable iff (rst)
        (sio.dio_oe && sio.clk && $past(sio.clk)) |-> $stable(sio.dio))
        else $error("dio changed while serial clock high");

    // Pin released in the strobe gap and during key reads
    a_dio_oe: assert property (@(posedge clk) disable iff (rst)
        (state == st_idle || state == st_read) |-> !sio.dio_oe)
        else $error("dio_oe high outside a write");

    a_stb_rst: assert property (@(posedge clk) $past(rst) |-> sio.stb)
        else $error("strobe low after reset");

endmodule

bind tm1638_board_controller board_assert i_assert
(
    .clk   ( clk   ),
    .rst   ( rst   ),
    .sio   ( sio   ),
    .state ( state )
);

`default_nettype wire

// File: verif/tb_board_specific_top.sv
`default_nettype none

`include "board_config.svh"

module tb_board_specific_top;
    import board_pkg::*;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_rows       = 8;
    localparam int frame_cycles = 64 * 2 * `I2S_SCK_DIV;
    localparam int refr_cycles  = 24 * 20 * `SIO_CLK_DIV;   // Upper bound of one refresh
    localparam int limit        = (n_rows + 2) * (2 * frame_cycles + 4 * refr_cycles);

    typedef struct packed {
        logic [8*14-1:0] name;
        sample_t         sample;     // Sent by the microphone model
        logic [1:0]      key;        // Onboard keys, active low
        key_t            pkeys;      // Panel keys, pressed is 1
        sample_t         shown;      // Sample expected on LEDs and digits
    } row_t;

    logic       clk = 1'b0;
    logic [1:0] key;
    logic [3:0] sw;
    logic       btn_reset_n;
    logic       mic_sd;
    logic       sio_dio_in;
    led_t       led;
    logic       sio_clk, sio_stb, sio_dio, sio_dio_oe, mic_sck, mic_ws;

    row_t    rows [n_rows];
    key_t    panel_keys;
    sample_t next_sample, cur_sample;
    seg_t    seg_rx [8];             // Decoded from the panel bus
    logic [7:0] led_rx [8];
    int      ws_rises, refreshes, cycles, n_mismatch, n_other;
    int      seed;

    board_specific_top i_dut
    (
        .fpga_clk1_50 ( clk         ),
        .key          ( key         ),
        .sw           ( sw          ),
        .btn_reset_n  ( btn_reset_n ),
        .mic_sd       ( mic_sd      ),
        .sio_dio_in   ( sio_dio_in  ),
        .led          ( led         ),
        .sio_clk      ( sio_clk     ),
        .sio_stb      ( sio_stb     ),
        .sio_dio      ( sio_dio     ),
        .sio_dio_oe   ( sio_dio_oe  ),
        .mic_sck      ( mic_sck     ),
        .mic_ws       ( mic_ws      )
    );

    initial
    begin
        forever #4 clk = ~clk;
    end

    // Seven-segment code as the panel sees it, a in bit 0
    function automatic seg_t panel_seg(input logic [3:0] h);
        case (h)
            4'h0: panel_seg = 8'h3F;
            4'h1: panel_seg = 8'h06;
            4'h2: panel_seg = 8'h5B;
            4'h3: panel_seg = 8'h4F;
            4'h4: panel_seg = 8'h66;
            4'h5: panel_seg = 8'h6D;
            4'h6: panel_seg = 8'h7D;
            4'h7: panel_seg = 8'h07;
            4'h8: panel_seg = 8'h7F;
            4'h9: panel_seg = 8'h6F;
            4'hA: panel_seg = 8'h77;
            4'hB: panel_seg = 8'h7C;    // Lower case b
            4'hC: panel_seg = 8'h39;
            4'hD: panel_seg = 8'h5E;    // Lower case d
            4'hE: panel_seg = 8'h79;
            default: panel_seg = 8'h71;
        endcase
    endfunction

    // ------------------------------------------------------------
    // I2S microphone model

    always @(negedge clk)
    begin : mic_model
        static logic sck_q = 1'b0;
        static logic ws_q  = 1'b0;
        static int   slot  = 0;
        if (sck_q && !mic_sck)
        begin
            if (ws_q && !mic_ws)
            begin
                slot       = 0;                  // New frame
                cur_sample = next_sample;
            end
            else
                slot++;
        end
        if (!ws_q && mic_ws)
            ws_rises++;
        sck_q  = mic_sck;
        ws_q   = mic_ws;
        mic_sd <= (slot >= 1 && slot <= 24) ? cur_sample[24 - slot] : 1'b0;
    end

    // ------------------------------------------------------------
    // TM1638 panel model

    always @(negedge clk)
    begin : panel_model
        static logic       clk_q   = 1'b1;
        static logic       stb_q   = 1'b1;
        static logic       reading = 1'b0;
        static logic [7:0] sreg    = '0;
        static logic [7:0] cmd     = '0;
        static int         nbits   = 0;
        static int         nbytes  = 0;
        static int         rbit    = 0;
        if (stb_q && !sio_stb)
        begin
            nbits   = 0;
            nbytes  = 0;
            reading = 1'b0;
        end
        else if (!stb_q && sio_stb)
        begin
            if (reading)
                refreshes++;                     // Read strobe ends a refresh
            reading = 1'b0;
        end
        if (!sio_stb && !clk_q && sio_clk && !reading)
        begin
            sreg = {sio_dio, sreg[7:1]};         // LSB first
            nbits++;
            if (nbits == 8)
            begin
                if (nbytes == 0)
                begin
                    cmd = sreg;
                    if (sreg == 8'h42)
                    begin
                        reading = 1'b1;
                        rbit    = 0;
                    end
                end
                else if (cmd == 8'hC0 && nbytes <= 16)
                begin
                    if (nbytes % 2 == 1)
                        seg_rx[(nbytes - 1) / 2] = sreg;
                    else
                        led_rx[(nbytes - 1) / 2] = sreg;
                end
                nbits = 0;
                nbytes++;
            end
        end
        if (!sio_stb && clk_q && !sio_clk && reading)
        begin
            case (rbit % 8)
                0:       sio_dio_in <= panel_keys[rbit / 8];
                4:       sio_dio_in <= panel_keys[rbit / 8 + 4];
                default: sio_dio_in <= 1'b0;
            endcase
            rbit++;
        end
        clk_q = sio_clk;
        stb_q = sio_stb;
    end

    // ------------------------------------------------------------
    // Waits and checks

    task automatic wait_refreshes(input int n);
        int target;
        target = refreshes + n;
        while (refreshes < target)
            @(negedge clk);
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = ws_rises + n;
        while (ws_rises < target)
            @(negedge clk);
        repeat (3) @(negedge clk);               // Value, then hold register
    endtask

    task automatic check_val(input string name, input string what,
                             input logic [23:0] exp, input logic [23:0] act);
        if (exp !== act)
        begin
            $display("mismatch %0s %0s: expected %0h actual %0h", name, what, exp, act);
            n_mismatch++;
        end
    endtask

    task automatic check_panel(input string name, input sample_t shown);
        seg_t exp;
        for (int i = 0; i < 8; i++)
        begin
            exp = (i < 6) ? panel_seg(shown[i * 4 +: 4]) : 8'h00;
            check_val(name, $sformatf("seg%0d", i), 24'(exp), 24'(seg_rx[i]));
            check_val(name, $sformatf("panel led%0d", i), 24'(shown[16 + i]),
                      24'(led_rx[i]));
        end
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > limit)
        begin
            $display("timeout: no result after %0d cycles", limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial
    begin
        string name;
        key         = 2'b11;
        sw          = 4'b1000;                   // Reset from top switch
        btn_reset_n = 1'b1;
        mic_sd      = 1'b0;
        sio_dio_in  = 1'b0;
        panel_keys  = '0;
        next_sample = '0;
        cur_sample  = '0;
        ws_rises    = 0;
        refreshes   = 0;
        cycles      = 0;
        n_mismatch  = 0;
        n_other     = 0;
        seed        = 32'h8f70ab98;

        rows[0] = '{"fixed_pos", 24'h123456, 2'b11, 8'h00, 24'h123456};
        rows[1] = '{"fixed_neg", 24'hABCDEF, 2'b11, 8'h00, 24'hABCDEF};
        rows[2] = '{"random_a",  24'($random(seed)), 2'b11, 8'h00, 24'h0};
        rows[3] = '{"random_b",  24'($random(seed)), 2'b11, 8'h00, 24'h0};
        rows[4] = '{"key0_hold", 24'h0F0F0F, 2'b10, 8'h00, 24'h0};
        rows[5] = '{"key0_free", 24'h789ABC, 2'b11, 8'h00, 24'h789ABC};
        rows[6] = '{"panel_hold", 24'h13579B, 2'b11, 8'h01, 24'h789ABC};
        rows[7] = '{"panel_free", 24'h2468AC, 2'b11, 8'h00, 24'h2468AC};
        rows[2].shown = rows[2].sample;
        rows[3].shown = rows[3].sample;
        rows[4].shown = rows[3].sample;          // Frozen at prior sample

        repeat (3) @(negedge clk);
        sw = 4'b0000;
        @(negedge clk);
        if (!sio_stb || sio_dio_oe)
        begin
            $display("panel pins not idle after reset");
            n_other++;
        end
        if (!sio_clk || mic_sck || mic_ws)
        begin
            $display("serial clocks not idle after reset");
            n_other++;
        end
        check_val("reset", "led", 24'h0, 24'(led));
        wait_refreshes(1);
        check_panel("reset", 24'h0);

        for (int r = 0; r < n_rows; r++)
        begin
            name = $sformatf("%0s", rows[r].name);
            key        = rows[r].key;
            panel_keys = rows[r].pkeys;
            wait_refreshes(2);                   // Panel keys reach the design
            next_sample = rows[r].sample;
            wait_frames(2);
            check_val(name, "led", 24'(rows[r].shown[23:16]), 24'(led));
            wait_refreshes(2);
            check_panel(name, rows[r].shown);
        end

        btn_reset_n = 1'b0;
        repeat (3) @(negedge clk);
        check_val("button_reset", "led", 24'h0, 24'(led));
        btn_reset_n = 1'b1;

        $display("errors: %0d mismatches, %0d other", n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
hw/board_pkg.sv
hw/inmp441_mic_i2s_receiver.sv
hw/tm1638_board_controller.sv
hw/top.sv
hw/board_specific_top.sv
verif/board_assert.sv
verif/tb_board_specific_top.sv

// File: Makefile
# Verilator build and run of the board testbench

VERILATOR ?= verilator
TOP       ?= tb_board_specific_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

FILELIST  := files.f
SRCS      := $(shell grep -v '^+' $(FILELIST))
HDRS      := include/board_config.svh
BIN       := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)

check: run
	@if grep -q '>>> FAIL' $(LOG) || ! grep -q '>>> PASS' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
